//--- logic/aes_pkg.sv
package aes_pkg;

    typedef logic [127:0] block_t;
    typedef logic [31:0]  word_t;
    typedef logic [7:0]   byte_t;
    typedef logic [3:0]   key_idx_t;

    localparam key_idx_t NUM_ROUNDS = 4'd10;

    function automatic byte_t xtime(byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byte_t gf_mul(byte_t a, byte_t b);
        byte_t p;
        byte_t x;
        p = '0;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ x;
            end
            x = xtime(x);
        end
        return p;
    endfunction

    // b^254 by repeated squaring, zero stays zero
    function automatic byte_t gf_inv(byte_t b);
        byte_t sq;
        byte_t acc;
        sq  = b;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    function automatic byte_t rotl8(byte_t b, int n);
        return (b << n) | (b >> (8 - n));
    endfunction

    function automatic byte_t sbox(byte_t b);
        byte_t v;
        v = gf_inv(b);
        return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
    endfunction

    // undo the affine map first, then invert
    function automatic byte_t inv_sbox(byte_t b);
        return gf_inv(rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05);
    endfunction

    function automatic block_t sub_bytes(block_t s);
        block_t r;
        for (int i = 0; i < 16; i++) begin
            r[8 * i +: 8] = sbox(s[8 * i +: 8]);
        end
        return r;
    endfunction

    function automatic block_t inv_sub_bytes(block_t s);
        block_t r;
        for (int i = 0; i < 16; i++) begin
            r[8 * i +: 8] = inv_sbox(s[8 * i +: 8]);
        end
        return r;
    endfunction

    // byte n = 4*col + row sits at bits [127-8n -: 8]
    function automatic block_t rotate_rows(block_t s, bit inv);
        block_t r;
        int     src;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                src = inv ? (c + 4 - row) % 4 : (c + row) % 4;
                r[127 - 8 * (4 * c + row) -: 8] = s[127 - 8 * (4 * src + row) -: 8];
            end
        end
        return r;
    endfunction

    function automatic block_t shift_rows(block_t s);
        return rotate_rows(s, 1'b0);
    endfunction

    function automatic block_t inv_shift_rows(block_t s);
        return rotate_rows(s, 1'b1);
    endfunction

    // circulant matrix, each row is the previous one rotated right
    function automatic word_t mix_col(word_t w, bit inv);
        byte_t m [4];
        byte_t acc;
        word_t r;
        if (inv) begin
            m = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
        end else begin
            m = '{8'h02, 8'h03, 8'h01, 8'h01};
        end
        for (int i = 0; i < 4; i++) begin
            acc = '0;
            for (int j = 0; j < 4; j++) begin
                acc = acc ^ gf_mul(m[(j + 4 - i) % 4], w[31 - 8 * j -: 8]);
            end
            r[31 - 8 * i -: 8] = acc;
        end
        return r;
    endfunction

    function automatic block_t mix_all(block_t s, bit inv);
        block_t r;
        for (int c = 0; c < 4; c++) begin
            r[127 - 32 * c -: 32] = mix_col(s[127 - 32 * c -: 32], inv);
        end
        return r;
    endfunction

    function automatic block_t mix_columns(block_t s);
        return mix_all(s, 1'b0);
    endfunction

    function automatic block_t inv_mix_columns(block_t s);
        return mix_all(s, 1'b1);
    endfunction

    function automatic word_t sub_word(word_t w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    function automatic word_t rot_word(word_t w);
        return {w[23:0], w[31:24]};
    endfunction

    // x^(i-1) in GF(2^8), top byte only
    function automatic word_t rcon(key_idx_t i);
        byte_t r;
        r = 8'h01;
        for (int k = 1; k < 10; k++) begin
            if (k < i) begin
                r = xtime(r);
            end
        end
        return {r, 24'h000000};
    endfunction

endpackage

//--- logic/core_pkg.sv
package core_pkg;

    typedef enum logic {
        op_encrypt = 1'b0,
        op_decrypt = 1'b1
    } op_e;

    typedef enum logic [2:0] {
        step_idle      = 3'd0,
        step_add_key   = 3'd1,
        step_enc_round = 3'd2,
        step_dec_round = 3'd3,
        step_enc_final = 3'd4,
        step_dec_final = 3'd5
    } step_e;

    typedef enum logic {
        st_idle = 1'b0,
        st_run  = 1'b1
    } ctrl_state_e;

endpackage

//--- logic/round_if.sv
`timescale 1ns/1ps

interface round_if;

    // step and key index come from the decoder
    core_pkg::step_e   step;
    aes_pkg::key_idx_t key_idx;

    // combinational read of the selected round key
    aes_pkg::block_t   rk;

    // cipher state register of the executor
    aes_pkg::block_t   st;

    modport ctrl (
        output step,
        output key_idx
    );

    modport keys (
        input  key_idx,
        output rk
    );

    modport exec (
        input  step,
        input  rk,
        output st
    );

    modport res (
        input  step,
        input  rk,
        input  st
    );

endinterface

//--- logic/aes_key_schedule.sv
`timescale 1ns/1ps

module aes_key_schedule (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            key_load,
    input  aes_pkg::block_t key,
    output logic            key_ready,
    round_if.keys           rif
);

    aes_pkg::block_t   rk_q [0:aes_pkg::NUM_ROUNDS];
    aes_pkg::key_idx_t fill_cnt;
    aes_pkg::key_idx_t nxt_idx;
    aes_pkg::block_t   src;
    aes_pkg::block_t   nxt_rk;
    aes_pkg::word_t    w0;
    aes_pkg::word_t    w1;
    aes_pkg::word_t    w2;
    aes_pkg::word_t    w3;
    logic              filling;

    assign filling = (fill_cnt != 4'd0);

    // round key 1 is derived straight from the loaded key
    assign nxt_idx = key_load ? 4'd1 : fill_cnt + 4'd1;
    assign src     = key_load ? key : rk_q[fill_cnt];

    assign w0 = src[127:96] ^ aes_pkg::sub_word(aes_pkg::rot_word(src[31:0]))
              ^ aes_pkg::rcon(nxt_idx);
    assign w1 = src[95:64] ^ w0;
    assign w2 = src[63:32] ^ w1;
    assign w3 = src[31:0] ^ w2;
    assign nxt_rk = {w0, w1, w2, w3};

    always_ff @(posedge clk) begin
        if (key_load) begin
            rk_q[0] <= key;
        end
        if (key_load || filling) begin
            rk_q[nxt_idx] <= nxt_rk;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_cnt  <= 4'd0;
            key_ready <= 1'b0;
        end else if (key_load) begin
            fill_cnt  <= 4'd1;
            key_ready <= 1'b0;
        end else if (filling) begin
            if (nxt_idx == aes_pkg::NUM_ROUNDS) begin
                fill_cnt  <= 4'd0;
                key_ready <= 1'b1;
            end else begin
                fill_cnt <= nxt_idx;
            end
        end
    end

    assign rif.rk = rk_q[rif.key_idx];

    // expansion takes nine more edges after the load
    a_no_reload: assert property (@(posedge clk) disable iff (!arst_n)
        key_load |=> !key_load [*9])
        else $error("key_load while round keys are being expanded");

endmodule

//--- logic/aes_cmd_decode.sv
`timescale 1ns/1ps

module aes_cmd_decode (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          start,
    input  core_pkg::op_e op,
    input  logic          key_ready,
    output logic          busy,
    round_if.ctrl         rif
);

    core_pkg::ctrl_state_e state;
    aes_pkg::key_idx_t     rnd;
    core_pkg::op_e         op_q;
    logic                  accept;
    logic                  last;
    logic                  enc;

    assign busy   = (state == core_pkg::st_run);
    assign accept = start && key_ready && !busy;
    assign last   = (rnd == aes_pkg::NUM_ROUNDS);
    assign enc    = (op_q == core_pkg::op_encrypt);

    always_comb begin
        rif.step    = core_pkg::step_idle;
        rif.key_idx = 4'd0;
        if (busy) begin
            if (last) begin
                rif.step = enc ? core_pkg::step_enc_final : core_pkg::step_dec_final;
            end else begin
                rif.step = enc ? core_pkg::step_enc_round : core_pkg::step_dec_round;
            end
            // decrypt walks the keys from the top down
            rif.key_idx = enc ? rnd : aes_pkg::NUM_ROUNDS - rnd;
        end else if (accept) begin
            rif.step    = core_pkg::step_add_key;
            rif.key_idx = (op == core_pkg::op_encrypt) ? 4'd0 : aes_pkg::NUM_ROUNDS;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= core_pkg::st_idle;
            rnd   <= 4'd0;
            op_q  <= core_pkg::op_encrypt;
        end else if (accept) begin
            state <= core_pkg::st_run;
            rnd   <= 4'd1;
            op_q  <= op;
        end else if (busy) begin
            if (last) begin
                state <= core_pkg::st_idle;
                rnd   <= 4'd0;
            end else begin
                rnd <= rnd + 4'd1;
            end
        end
    end

    a_rnd_range: assert property (@(posedge clk) disable iff (!arst_n)
        rnd <= aes_pkg::NUM_ROUNDS)
        else $error("round counter past the last round");

    // a block occupies exactly ten busy cycles
    a_busy_len: assert property (@(posedge clk) disable iff (!arst_n)
        accept |=> busy [*10] ##1 !busy)
        else $error("block did not take ten busy cycles");

endmodule

//--- logic/aes_round_exec.sv
`timescale 1ns/1ps

module aes_round_exec (
    input  logic            clk,
    input  logic            arst_n,
    input  aes_pkg::block_t data_in,
    round_if.exec           rif
);

    aes_pkg::block_t enc_nxt;
    aes_pkg::block_t dec_nxt;
    aes_pkg::block_t dec_mid;

    assign enc_nxt = aes_pkg::mix_columns(aes_pkg::shift_rows(aes_pkg::sub_bytes(rif.st)))
                   ^ rif.rk;

    // key add comes before the inverse mix in the inverse cipher
    assign dec_mid = aes_pkg::inv_sub_bytes(aes_pkg::inv_shift_rows(rif.st)) ^ rif.rk;
    assign dec_nxt = aes_pkg::inv_mix_columns(dec_mid);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rif.st <= '0;
        end else begin
            case (rif.step)
                core_pkg::step_add_key: begin
                    rif.st <= data_in ^ rif.rk;
                end
                core_pkg::step_enc_round: begin
                    rif.st <= enc_nxt;
                end
                core_pkg::step_dec_round: begin
                    rif.st <= dec_nxt;
                end
                default: begin
                    rif.st <= rif.st;
                end
            endcase
        end
    end

endmodule

//--- logic/aes_final_round.sv
`timescale 1ns/1ps

module aes_final_round (
    input  logic            clk,
    input  logic            arst_n,
    round_if.res            rif,
    output aes_pkg::block_t data_out,
    output logic            out_valid
);

    aes_pkg::block_t enc_out;
    aes_pkg::block_t dec_out;
    logic            enc_fin;
    logic            dec_fin;

    assign enc_fin = (rif.step == core_pkg::step_enc_final);
    assign dec_fin = (rif.step == core_pkg::step_dec_final);

    // last round has no column mix
    assign enc_out = aes_pkg::shift_rows(aes_pkg::sub_bytes(rif.st)) ^ rif.rk;
    assign dec_out = aes_pkg::inv_sub_bytes(aes_pkg::inv_shift_rows(rif.st)) ^ rif.rk;

    always_ff @(posedge clk) begin
        if (enc_fin) begin
            data_out <= enc_out;
        end else if (dec_fin) begin
            data_out <= dec_out;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= enc_fin || dec_fin;
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |=> !out_valid)
        else $error("out_valid high two cycles in a row");

endmodule

//--- logic/aes_core.sv
`timescale 1ns/1ps

module aes_core (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         key_load,
    input  logic [127:0] key,
    input  logic         start,
    input  logic         op,
    input  logic [127:0] data_in,
    output logic         key_ready,
    output logic         busy,
    output logic [127:0] data_out,
    output logic         out_valid
);

    round_if rif ();

    aes_key_schedule u_key_schedule (
        .clk       (clk),
        .arst_n    (arst_n),
        .key_load  (key_load),
        .key       (key),
        .key_ready (key_ready),
        .rif       (rif.keys)
    );

    aes_cmd_decode u_cmd_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .op        (core_pkg::op_e'(op)),
        .key_ready (key_ready),
        .busy      (busy),
        .rif       (rif.ctrl)
    );

    aes_round_exec u_round_exec (
        .clk     (clk),
        .arst_n  (arst_n),
        .data_in (data_in),
        .rif     (rif.exec)
    );

    aes_final_round u_final_round (
        .clk       (clk),
        .arst_n    (arst_n),
        .rif       (rif.res),
        .data_out  (data_out),
        .out_valid (out_valid)
    );

    // round keys must stay stable while a block is running
    a_no_load_busy: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> !key_load)
        else $error("key_load while a block is in progress");

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

//--- sim/tb_aes_core.sv
`timescale 1ns/1ps

module tb_aes_core;

    localparam int WAIT_LIMIT     = 40;
    localparam int KEY_COUNT      = 20;
    localparam int BLOCKS_PER_KEY = 4;

    // FIPS-197 appendix C.1
    localparam logic [127:0] FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic         clk;
    logic         arst_n;
    logic         key_load;
    logic [127:0] key;
    logic         start;
    logic         op;
    logic [127:0] data_in;
    logic         key_ready;
    logic         busy;
    logic [127:0] data_out;
    logic         out_valid;

    int           mismatches;
    int           failures;
    logic [31:0]  lfsr_state;

    tb_clock u_clock (
        .clk (clk)
    );

    aes_core u_aes_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .key_load  (key_load),
        .key       (key),
        .start     (start),
        .op        (op),
        .data_in   (data_in),
        .key_ready (key_ready),
        .busy      (busy),
        .data_out  (data_out),
        .out_valid (out_valid)
    );

    // right-shifting form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [127:0] random_block();
        logic [127:0] b;
        for (int i = 0; i < 128; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
        return b;
    endfunction

    task automatic mismatch_block(input string name, input logic [127:0] exp,
                                  input logic [127:0] act);
        mismatches++;
        $display("MISMATCH %s expected %h actual %h", name, exp, act);
    endtask

    task automatic mismatch_int(input string name, input int exp, input int act);
        mismatches++;
        $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
    endtask

    task automatic note_failure(input string what);
        failures++;
        $display("ERROR %s", what);
    endtask

    // ready expected in cycle 10 when key_load is in cycle 0
    task automatic load_key(input string name, input logic [127:0] k);
        int cyc;
        @(posedge clk);
        key_load <= 1'b1;
        key      <= k;
        @(posedge clk);
        key_load <= 1'b0;
        cyc = 1;
        @(negedge clk);
        while (key_ready !== 1'b1 && cyc < WAIT_LIMIT) begin
            cyc++;
            @(negedge clk);
        end
        if (key_ready !== 1'b1) begin
            note_failure({name, ": key_ready never went high"});
        end else if (cyc != 10) begin
            mismatch_int({name, " key_ready latency"}, 10, cyc);
        end
    endtask

    // returns at the start of cycle 1
    task automatic pulse_start(input logic op_v, input logic [127:0] blk);
        @(posedge clk);
        start   <= 1'b1;
        op      <= op_v;
        data_in <= blk;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_result(input string name, input int first_cyc,
                               output logic [127:0] res);
        int cyc;
        cyc = first_cyc;
        @(negedge clk);
        while (out_valid !== 1'b1 && cyc < WAIT_LIMIT) begin
            if (busy !== 1'b1 && cyc <= 10) begin
                note_failure($sformatf("%s: busy low in cycle %0d", name, cyc));
            end
            cyc++;
            @(negedge clk);
        end
        res = data_out;
        if (out_valid !== 1'b1) begin
            note_failure({name, ": out_valid never went high"});
        end else if (cyc != 11) begin
            mismatch_int({name, " out_valid latency"}, 11, cyc);
        end
    endtask

    task automatic run_block(input string name, input logic op_v, input logic [127:0] blk,
                             output logic [127:0] res);
        pulse_start(op_v, blk);
        wait_result(name, 1, res);
    endtask

    initial begin
        logic [127:0] res;
        logic [127:0] rkey;
        logic [127:0] pt;
        logic [127:0] ct;
        string        name;
        mismatches = 0;
        failures   = 0;
        lfsr_state = 32'h99a1_acec;
        arst_n     = 1'b0;
        key_load   = 1'b0;
        key        = '0;
        start      = 1'b0;
        op         = 1'b0;
        data_in    = '0;

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (key_ready !== 1'b0 || busy !== 1'b0 || out_valid !== 1'b0) begin
            note_failure("key_ready, busy or out_valid not low after reset");
        end

        load_key("fips key load", FIPS_KEY);
        run_block("fips encrypt", 1'b0, FIPS_PT, res);
        if (res !== FIPS_CT) begin
            mismatch_block("fips encrypt", FIPS_CT, res);
        end
        run_block("fips decrypt", 1'b1, FIPS_CT, res);
        if (res !== FIPS_PT) begin
            mismatch_block("fips decrypt", FIPS_PT, res);
        end

        // second start in cycle 5 must be dropped
        pulse_start(1'b0, FIPS_PT);
        repeat (4) @(posedge clk);
        start   <= 1'b1;
        op      <= 1'b1;
        data_in <= random_block();
        @(posedge clk);
        start <= 1'b0;
        wait_result("start while busy", 6, res);
        if (res !== FIPS_CT) begin
            mismatch_block("start while busy", FIPS_CT, res);
        end
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                note_failure($sformatf("extra out_valid pulse %0d cycles later", i + 1));
            end
            if (data_out !== FIPS_CT) begin
                mismatch_block("held data_out", FIPS_CT, data_out);
            end
        end

        // decrypt start lands in cycle 11 of the encrypt
        pulse_start(1'b0, FIPS_PT);
        repeat (10) @(posedge clk);
        start   <= 1'b1;
        op      <= 1'b1;
        data_in <= FIPS_CT;
        @(negedge clk);
        if (out_valid !== 1'b1) begin
            note_failure("back-to-back: first out_valid missing in cycle 11");
        end
        if (data_out !== FIPS_CT) begin
            mismatch_block("back-to-back encrypt", FIPS_CT, data_out);
        end
        @(posedge clk);
        start <= 1'b0;
        wait_result("back-to-back decrypt", 1, res);
        if (res !== FIPS_PT) begin
            mismatch_block("back-to-back decrypt", FIPS_PT, res);
        end

        for (int k = 0; k < KEY_COUNT; k++) begin
            rkey = random_block();
            load_key($sformatf("random key %0d load", k), rkey);
            for (int b = 0; b < BLOCKS_PER_KEY; b++) begin
                name = $sformatf("round trip key %0d block %0d", k, b);
                pt = random_block();
                run_block(name, 1'b0, pt, ct);
                if (ct === pt) begin
                    note_failure({name, ": ciphertext equals plaintext"});
                end
                run_block(name, 1'b1, ct, res);
                if (res !== pt) begin
                    mismatch_block(name, pt, res);
                end
            end
        end

        $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- project.f
logic/aes_pkg.sv
logic/core_pkg.sv
logic/round_if.sv
logic/aes_key_schedule.sv
logic/aes_cmd_decode.sv
logic/aes_round_exec.sv
logic/aes_final_round.sv
logic/aes_core.sv
sim/tb_clock.sv
sim/tb_aes_core.sv
